//--- logic/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

  // ------------------------------
  // Device geometry
  // ------------------------------
  localparam int SDRAM_MHZ    = 50;
  localparam int SDRAM_BANK_W = 2;
  localparam int SDRAM_ROW_W  = 13;
  localparam int SDRAM_COL_W  = 9;
  localparam int SDRAM_BANKS  = 2 ** SDRAM_BANK_W;
  localparam int SDRAM_DATA_W = 32;
  localparam int SDRAM_DQM_W  = 4;

  // Byte address split: column 10:2, bank 12:11, row 25:13
  localparam int ADDR_COL_LSB  = 2;
  localparam int ADDR_BANK_LSB = ADDR_COL_LSB + SDRAM_COL_W;
  localparam int ADDR_ROW_LSB  = ADDR_BANK_LSB + SDRAM_BANK_W;

  // ------------------------------
  // Timing in clock cycles
  // ------------------------------
  localparam int CYCLE_TIME_NS        = 1000 / SDRAM_MHZ;
  // 100 us power-up wait
  localparam int SDRAM_START_DELAY    = 100000 / CYCLE_TIME_NS;
  // 8192 rows every 64 ms
  localparam int SDRAM_REFRESH_CYCLES = (64000 * SDRAM_MHZ) / (2 ** SDRAM_ROW_W) - 1;
  localparam int SDRAM_TRCD_CYCLES    = (20 + (CYCLE_TIME_NS - 1)) / CYCLE_TIME_NS;
  localparam int SDRAM_TRP_CYCLES     = (20 + (CYCLE_TIME_NS - 1)) / CYCLE_TIME_NS;
  localparam int SDRAM_TRFC_CYCLES    = (60 + (CYCLE_TIME_NS - 1)) / CYCLE_TIME_NS;
  localparam int SDRAM_READ_LATENCY   = 2;
  localparam int DELAY_W              = 4;
  localparam int REFRESH_CNT_W        = 17;

  // Init steps, as refresh timer values while counting down
  localparam int INIT_CKE_AT       = 50;
  localparam int INIT_PRECHARGE_AT = 40;
  localparam int INIT_REFRESH_A_AT = 30;
  localparam int INIT_REFRESH_B_AT = 20;
  localparam int INIT_MODE_AT      = 10;

  // Mode word: write burst programmed, CAS 2, sequential, burst 1
  localparam logic [SDRAM_ROW_W-1:0] MODE_REG = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

  // A10 doubles as auto-precharge and all-banks select
  localparam int AUTO_PRECHARGE_BIT = 10;
  localparam int ALL_BANKS_BIT      = 10;

  // ------------------------------
  // Command word
  // ------------------------------
  // Codes are {cs, ras, cas, we}, all active low
  localparam logic [3:0] CMD_NOP       = 4'b0111;
  localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
  localparam logic [3:0] CMD_READ      = 4'b0101;
  localparam logic [3:0] CMD_WRITE     = 4'b0100;
  localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
  localparam logic [3:0] CMD_REFRESH   = 4'b0001;
  localparam logic [3:0] CMD_LOAD_MODE = 4'b0000;

  // Same word seen as code or as pins
  typedef union packed {
    logic [3:0] code;
    struct packed {
      logic cs;
      logic ras;
      logic cas;
      logic we;
    } pin;
  } sdram_cmd_t;

  // Main FSM states
  typedef enum logic [3:0] {
    ST_INIT      = 4'd0,
    ST_DELAY     = 4'd1,
    ST_IDLE      = 4'd2,
    ST_ACTIVATE  = 4'd3,
    ST_READ      = 4'd4,
    ST_READ_WAIT = 4'd5,
    ST_WRITE     = 4'd6,
    ST_PRECHARGE = 4'd7,
    ST_REFRESH   = 4'd8
  } sdram_state_t;

endpackage

`default_nettype wire

//--- logic/sdram_refresh_timer.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      refresh_done_i,
  output logic [REFRESH_CNT_W-1:0] timer_value_o,
  output logic                     refresh_pending_o
);

  // First expiry ends init, 100 extra cycles leave room for init steps
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      timer_value_o     <= REFRESH_CNT_W'(SDRAM_START_DELAY + 100);
      refresh_pending_o <= 1'b0;
    end else if (timer_value_o == '0) begin
      // Reload interval, request a refresh
      timer_value_o     <= REFRESH_CNT_W'(SDRAM_REFRESH_CYCLES);
      refresh_pending_o <= 1'b1;
    end else begin
      timer_value_o <= timer_value_o - 1'b1;
      // Served by the FSM
      if (refresh_done_i) begin
        refresh_pending_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/sdram_bank_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_bank_tracker
  import sdram_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  sdram_state_t            state_i,
  input  wire                     precharge_all_i,
  input  wire [SDRAM_BANK_W-1:0]  req_bank_i,
  input  wire [SDRAM_ROW_W-1:0]   req_row_i,
  output logic                    row_hit_o,
  output logic                    bank_open_o,
  output logic                    any_open_o
);

  logic [SDRAM_BANKS-1:0] open_q;
  logic [SDRAM_ROW_W-1:0] active_row_q [SDRAM_BANKS];

  // Open flags per bank
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      open_q <= '0;
    end else if (state_i == ST_ACTIVATE) begin
      open_q[req_bank_i] <= 1'b1;
    end else if (state_i == ST_PRECHARGE) begin
      if (precharge_all_i) begin
        open_q <= '0;
      end else begin
        open_q[req_bank_i] <= 1'b0;
      end
    end
  end

  // Row held open in each bank
  always_ff @(posedge clk_i) begin
    if (state_i == ST_ACTIVATE) begin
      active_row_q[req_bank_i] <= req_row_i;
    end
  end

  assign bank_open_o = open_q[req_bank_i];
  assign row_hit_o   = open_q[req_bank_i] && (active_row_q[req_bank_i] == req_row_i);
  assign any_open_o  = |open_q;

  // FSM must close a bank before opening another row in it
  a_no_double_activate: assert property (@(posedge clk_i) disable iff (rst_i)
    state_i == ST_ACTIVATE |-> !open_q[req_bank_i]);

endmodule

`default_nettype wire

//--- logic/sdram_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_sequencer
  import sdram_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     rd_i,
  input  wire [SDRAM_DQM_W-1:0]   wr_i,
  input  wire                     refresh_pending_i,
  input  wire                     row_hit_i,
  input  wire                     bank_open_i,
  input  wire                     any_open_i,
  output sdram_state_t            state_o,
  output logic                    precharge_all_o,
  output logic                    accept_o
);

  sdram_state_t state_q, next_state, target_q, target_d, delay_state_q;
  logic [DELAY_W-1:0] delay_q, delay_d;
  logic req;

  assign req = rd_i || (wr_i != '0);

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    next_state = state_q;
    target_d   = target_q;
    case (state_q)
      // Leave init on the first timer expiry
      ST_INIT: begin
        if (refresh_pending_i) begin
          next_state = ST_IDLE;
        end
      end
      ST_IDLE: begin
        // Refresh first, close any open rows before it
        if (refresh_pending_i) begin
          next_state = any_open_i ? ST_PRECHARGE : ST_REFRESH;
          target_d   = ST_REFRESH;
        end else if (req) begin
          if (row_hit_i) begin
            next_state = rd_i ? ST_READ : ST_WRITE;
          end else begin
            // Miss closes the bank, empty bank goes straight to activate
            next_state = bank_open_i ? ST_PRECHARGE : ST_ACTIVATE;
            target_d   = rd_i ? ST_READ : ST_WRITE;
          end
        end
      end
      ST_ACTIVATE:  next_state = target_q;
      ST_READ:      next_state = ST_READ_WAIT;
      ST_READ_WAIT: next_state = ST_IDLE;
      ST_WRITE:     next_state = ST_IDLE;
      ST_PRECHARGE: next_state = (target_q == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
      ST_REFRESH:   next_state = ST_IDLE;
      ST_DELAY:     next_state = delay_state_q;
      default:      next_state = ST_IDLE;
    endcase
  end

  // ------------------------------
  // Wait cycles per state
  // ------------------------------
  always_comb begin
    case (state_q)
      ST_ACTIVATE:  delay_d = DELAY_W'(SDRAM_TRCD_CYCLES);
      ST_PRECHARGE: delay_d = DELAY_W'(SDRAM_TRP_CYCLES);
      ST_REFRESH:   delay_d = DELAY_W'(SDRAM_TRFC_CYCLES);
      // Back-to-back row-hit reads skip the latency wait
      ST_READ_WAIT: begin
        if (!refresh_pending_i && rd_i && row_hit_i) begin
          delay_d = '0;
        end else begin
          delay_d = DELAY_W'(SDRAM_READ_LATENCY);
        end
      end
      ST_DELAY:     delay_d = delay_q - 1'b1;
      default:      delay_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q       <= ST_INIT;
      target_q      <= ST_IDLE;
      delay_state_q <= ST_IDLE;
      delay_q       <= '0;
    end else begin
      target_q <= target_d;
      delay_q  <= delay_d;
      // Park in delay, remember where to resume
      if (delay_d != '0) begin
        state_q <= ST_DELAY;
        if (state_q != ST_DELAY) begin
          delay_state_q <= next_state;
        end
      end else begin
        state_q <= next_state;
      end
    end
  end

  assign state_o         = state_q;
  assign precharge_all_o = (state_q == ST_PRECHARGE) && (target_q == ST_REFRESH);
  assign accept_o        = (state_q == ST_READ) || (state_q == ST_WRITE);

  // Accepted request must sit on a row the tracker holds open
  a_accept_on_open_row: assert property (@(posedge clk_i) disable iff (rst_i)
    accept_o |-> req && row_hit_i);

endmodule

`default_nettype wire

//--- logic/sdram_cmd_issuer.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_issuer
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  sdram_state_t             state_i,
  input  wire                      precharge_all_i,
  input  wire [REFRESH_CNT_W-1:0]  timer_value_i,
  input  wire [31:0]               addr_i,
  input  wire [SDRAM_DQM_W-1:0]    wr_i,
  input  wire [31:0]               wdata_i,
  output sdram_cmd_t               cmd_o,
  output logic [SDRAM_ROW_W-1:0]   addr_o,
  output logic [SDRAM_BANK_W-1:0]  ba_o,
  output logic [SDRAM_DQM_W-1:0]   dqm_o,
  output logic [31:0]              data_o,
  output logic                     data_oe_o,
  output logic                     cke_o
);

  logic [SDRAM_ROW_W-1:0]  addr_row;
  logic [SDRAM_ROW_W-1:0]  addr_col;
  logic [SDRAM_BANK_W-1:0] addr_bank;

  // Request address fields
  assign addr_row  = addr_i[ADDR_ROW_LSB +: SDRAM_ROW_W];
  assign addr_bank = addr_i[ADDR_BANK_LSB +: SDRAM_BANK_W];
  assign addr_col  = {{(SDRAM_ROW_W - SDRAM_COL_W){1'b0}}, addr_i[ADDR_COL_LSB +: SDRAM_COL_W]};

  // ------------------------------
  // Command and address pins
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_o.code <= CMD_NOP;
      addr_o     <= '0;
      ba_o       <= '0;
      dqm_o      <= '0;
      data_oe_o  <= 1'b0;
      cke_o      <= 1'b0;
    end else begin
      // NOP unless the state says otherwise
      cmd_o.code <= CMD_NOP;
      addr_o     <= '0;
      ba_o       <= '0;
      data_oe_o  <= 1'b0;
      case (state_i)
        // Power-up steps keyed off the timer
        ST_INIT: begin
          if (timer_value_i == REFRESH_CNT_W'(INIT_CKE_AT)) begin
            cke_o <= 1'b1;
          end else if (timer_value_i == REFRESH_CNT_W'(INIT_PRECHARGE_AT)) begin
            cmd_o.code            <= CMD_PRECHARGE;
            addr_o[ALL_BANKS_BIT] <= 1'b1;
          end else if (timer_value_i == REFRESH_CNT_W'(INIT_REFRESH_A_AT) ||
                       timer_value_i == REFRESH_CNT_W'(INIT_REFRESH_B_AT)) begin
            cmd_o.code <= CMD_REFRESH;
          end else if (timer_value_i == REFRESH_CNT_W'(INIT_MODE_AT)) begin
            cmd_o.code <= CMD_LOAD_MODE;
            addr_o     <= MODE_REG;
          end
        end
        ST_ACTIVATE: begin
          cmd_o.code <= CMD_ACTIVE;
          addr_o     <= addr_row;
          ba_o       <= addr_bank;
        end
        // All banks ahead of refresh, else only the missed bank
        ST_PRECHARGE: begin
          cmd_o.code            <= CMD_PRECHARGE;
          addr_o[ALL_BANKS_BIT] <= precharge_all_i;
          ba_o                  <= precharge_all_i ? '0 : addr_bank;
        end
        ST_REFRESH: cmd_o.code <= CMD_REFRESH;
        ST_READ: begin
          cmd_o.code                 <= CMD_READ;
          addr_o                     <= addr_col;
          addr_o[AUTO_PRECHARGE_BIT] <= 1'b0;
          ba_o                       <= addr_bank;
          dqm_o                      <= '0;
        end
        // Byte enables become active-low mask
        ST_WRITE: begin
          cmd_o.code                 <= CMD_WRITE;
          addr_o                     <= addr_col;
          addr_o[AUTO_PRECHARGE_BIT] <= 1'b0;
          ba_o                       <= addr_bank;
          dqm_o                      <= ~wr_i;
          data_oe_o                  <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Write data, one beat
  always_ff @(posedge clk_i) begin
    if (state_i == ST_WRITE) begin
      data_o <= wdata_i;
    end
  end

  // Bus driven for exactly the WRITE cycle
  a_oe_single_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    data_oe_o |-> cmd_o.code == CMD_WRITE ##1 !data_oe_o);

endmodule

`default_nettype wire

//--- logic/sdram_read_path.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_read_path
  import sdram_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  sdram_state_t             state_i,
  input  wire [SDRAM_DATA_W-1:0]   sdram_din_i,
  output logic [SDRAM_DATA_W-1:0]  rdata_o,
  output logic                     ack_o
);

  logic [SDRAM_DATA_W-1:0]     sample0_q;
  logic [SDRAM_READ_LATENCY:0] rd_q;

  // Two sampling stages on the data input
  always_ff @(posedge clk_i) begin
    sample0_q <= sdram_din_i;
    rdata_o   <= sample0_q;
  end

  // ------------------------------
  // Reads in flight and ack
  // ------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_q  <= '0;
      ack_o <= 1'b0;
    end else begin
      // One marker per READ, lines up with sampled data
      rd_q  <= {rd_q[SDRAM_READ_LATENCY-1:0], state_i == ST_READ};
      ack_o <= (state_i == ST_WRITE) || rd_q[SDRAM_READ_LATENCY];
    end
  end

endmodule

`default_nettype wire

//--- logic/sdram_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl_top
  import sdram_pkg::*;
(
  // Requester side
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire [SDRAM_DQM_W-1:0]    wr_i,
  input  wire                      rd_i,
  input  wire [31:0]               addr_i,
  input  wire [SDRAM_DATA_W-1:0]   wdata_i,
  output logic                     accept_o,
  output logic                     ack_o,
  output logic [SDRAM_DATA_W-1:0]  rdata_o,
  // SDRAM side
  input  wire [SDRAM_DATA_W-1:0]   sdram_din_i,
  output logic                     sdram_clk_o,
  output logic                     sdram_cke_o,
  output logic                     sdram_cs_o,
  output logic                     sdram_ras_o,
  output logic                     sdram_cas_o,
  output logic                     sdram_we_o,
  output logic [SDRAM_DQM_W-1:0]   sdram_dqm_o,
  output logic [SDRAM_ROW_W-1:0]   sdram_addr_o,
  output logic [SDRAM_BANK_W-1:0]  sdram_ba_o,
  output logic [SDRAM_DATA_W-1:0]  sdram_dout_o,
  output logic                     sdram_dout_en_o
);

  sdram_state_t             state;
  sdram_cmd_t               cmd;
  logic                     precharge_all;
  logic                     refresh_pending;
  logic [REFRESH_CNT_W-1:0] timer_value;
  logic                     row_hit;
  logic                     bank_open;
  logic                     any_open;
  logic [SDRAM_BANK_W-1:0]  req_bank;
  logic [SDRAM_ROW_W-1:0]   req_row;

  assign req_bank = addr_i[ADDR_BANK_LSB +: SDRAM_BANK_W];
  assign req_row  = addr_i[ADDR_ROW_LSB +: SDRAM_ROW_W];

  // ------------------------------
  // Blocks
  // ------------------------------
  sdram_refresh_timer i_refresh_timer (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .refresh_done_i    (state == ST_REFRESH),
    .timer_value_o     (timer_value),
    .refresh_pending_o (refresh_pending)
  );

  sdram_bank_tracker i_bank_tracker (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .state_i         (state),
    .precharge_all_i (precharge_all),
    .req_bank_i      (req_bank),
    .req_row_i       (req_row),
    .row_hit_o       (row_hit),
    .bank_open_o     (bank_open),
    .any_open_o      (any_open)
  );

  sdram_sequencer i_sequencer (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .rd_i              (rd_i),
    .wr_i              (wr_i),
    .refresh_pending_i (refresh_pending),
    .row_hit_i         (row_hit),
    .bank_open_i       (bank_open),
    .any_open_i        (any_open),
    .state_o           (state),
    .precharge_all_o   (precharge_all),
    .accept_o          (accept_o)
  );

  sdram_cmd_issuer i_cmd_issuer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .state_i         (state),
    .precharge_all_i (precharge_all),
    .timer_value_i   (timer_value),
    .addr_i          (addr_i),
    .wr_i            (wr_i),
    .wdata_i         (wdata_i),
    .cmd_o           (cmd),
    .addr_o          (sdram_addr_o),
    .ba_o            (sdram_ba_o),
    .dqm_o           (sdram_dqm_o),
    .data_o          (sdram_dout_o),
    .data_oe_o       (sdram_dout_en_o),
    .cke_o           (sdram_cke_o)
  );

  sdram_read_path i_read_path (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .state_i     (state),
    .sdram_din_i (sdram_din_i),
    .rdata_o     (rdata_o),
    .ack_o       (ack_o)
  );

  // Device samples on the opposite edge
  assign sdram_clk_o = ~clk_i;

  // Command word onto its pins
  assign sdram_cs_o  = cmd.pin.cs;
  assign sdram_ras_o = cmd.pin.ras;
  assign sdram_cas_o = cmd.pin.cas;
  assign sdram_we_o  = cmd.pin.we;

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_model
  import sdram_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     cke_i,
  input  wire                     cs_i,
  input  wire                     ras_i,
  input  wire                     cas_i,
  input  wire                     we_i,
  input  wire [SDRAM_DQM_W-1:0]   dqm_i,
  input  wire [SDRAM_ROW_W-1:0]   addr_i,
  input  wire [SDRAM_BANK_W-1:0]  ba_i,
  input  wire [SDRAM_DATA_W-1:0]  dq_i,
  input  wire                     dq_oe_i,
  output logic [SDRAM_DATA_W-1:0] dq_o = '0
);

  sdram_cmd_t             cmd;
  logic [31:0]            mem [int];
  logic [SDRAM_BANKS-1:0] open_q = '0;
  logic [SDRAM_ROW_W-1:0] row_q [SDRAM_BANKS];
  int                     cycle = 0;
  int                     cke_cycle = -1;
  int                     access_errors = 0;

  // Command log, one entry per non-NOP command
  sdram_cmd_t             log_cmd [$];
  logic [SDRAM_ROW_W-1:0] log_addr [$];
  logic [SDRAM_BANK_W-1:0] log_ba [$];
  logic [SDRAM_BANKS-1:0] log_open [$];
  int                     log_cycle [$];

  assign cmd.code = {cs_i, ras_i, cas_i, we_i};

  // Unwritten words, pattern covers every address bit
  function automatic logic [31:0] fill_pattern(int key);
    return {8'h5A ^ key[23:16], key[23:0]};
  endfunction

  always @(posedge clk_i) begin
    int          key;
    logic [31:0] word;
    cycle = cycle + 1;
    if (cke_i && cke_cycle < 0) begin
      cke_cycle = cycle;
    end
    if (cke_i && cmd.code != CMD_NOP) begin
      log_cmd.push_back(cmd);
      log_addr.push_back(addr_i);
      log_ba.push_back(ba_i);
      log_open.push_back(open_q);
      log_cycle.push_back(cycle);
      key = int'({ba_i, row_q[ba_i], addr_i[SDRAM_COL_W-1:0]});
      case (cmd.code)
        CMD_ACTIVE: begin
          open_q[ba_i] = 1'b1;
          row_q[ba_i]  = addr_i;
        end
        CMD_PRECHARGE: begin
          if (addr_i[ALL_BANKS_BIT]) open_q = '0;
          else open_q[ba_i] = 1'b0;
        end
        CMD_REFRESH: begin
          if (open_q != '0) begin
            access_errors = access_errors + 1;
            $display("Model saw REFRESH while a row was open");
          end
        end
        CMD_READ, CMD_WRITE: begin
          if (!open_q[ba_i]) begin
            access_errors = access_errors + 1;
            $display("Model saw access to closed bank %0d", ba_i);
          end
          word = mem.exists(key) ? mem[key] : fill_pattern(key);
          if (cmd.code == CMD_READ) begin
            // Data lands one cycle after READ shows on the pins
            dq_o <= word;
          end else begin
            if (!dq_oe_i) begin
              access_errors = access_errors + 1;
              $display("Model saw WRITE without data output enable");
            end
            for (int b = 0; b < SDRAM_DQM_W; b++) begin
              if (!dqm_i[b]) word[b*8 +: 8] = dq_i[b*8 +: 8];
            end
            mem[key] = word;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_sdram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sdram_ctrl
  import sdram_pkg::*;
();

  logic        clk_i;
  logic        rst_i;
  logic [3:0]  wr_i;
  logic        rd_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic        accept_o;
  logic        ack_o;
  logic [31:0] rdata_o;
  logic [31:0] sdram_din;
  logic        sdram_clk, sdram_cke, sdram_cs, sdram_ras, sdram_cas, sdram_we;
  logic [3:0]  sdram_dqm;
  logic [12:0] sdram_addr;
  logic [1:0]  sdram_ba;
  logic [31:0] sdram_dout;
  logic        sdram_dout_en;

  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          test_start_errors;
  int          cycle = 0;
  logic [15:0] lfsr = 16'd14;
  logic [31:0] shadow [int];

  sdram_ctrl_top i_dut (
    .clk_i(clk_i), .rst_i(rst_i), .wr_i(wr_i), .rd_i(rd_i), .addr_i(addr_i),
    .wdata_i(wdata_i), .accept_o(accept_o), .ack_o(ack_o), .rdata_o(rdata_o),
    .sdram_din_i(sdram_din), .sdram_clk_o(sdram_clk), .sdram_cke_o(sdram_cke),
    .sdram_cs_o(sdram_cs), .sdram_ras_o(sdram_ras), .sdram_cas_o(sdram_cas),
    .sdram_we_o(sdram_we), .sdram_dqm_o(sdram_dqm), .sdram_addr_o(sdram_addr),
    .sdram_ba_o(sdram_ba), .sdram_dout_o(sdram_dout), .sdram_dout_en_o(sdram_dout_en)
  );

  sdram_model i_model (
    .clk_i(clk_i), .cke_i(sdram_cke), .cs_i(sdram_cs), .ras_i(sdram_ras),
    .cas_i(sdram_cas), .we_i(sdram_we), .dqm_i(sdram_dqm), .addr_i(sdram_addr),
    .ba_i(sdram_ba), .dq_i(sdram_dout), .dq_oe_i(sdram_dout_en), .dq_o(sdram_din)
  );

  // ------------------------------
  // Clock and cycle count
  // ------------------------------
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Expected word after a byte-masked write
  function automatic logic [31:0] merge_word(logic [31:0] old_w, logic [31:0] new_w,
                                             logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Word key as the device sees it: bank, row, column
  function automatic int word_key(logic [31:0] a);
    return int'({a[12:11], a[25:13], a[10:2]});
  endfunction

  function automatic logic [31:0] shadow_read(int key);
    return shadow.exists(key) ? shadow[key] : {8'h5A ^ key[23:16], key[23:0]};
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_cmd(string name, sdram_cmd_t exp, sdram_cmd_t act);
    if (exp.code !== act.code) begin
      errors++;
      $display("CHECK FAILED %s expected %04b actual %04b", name, exp.code, act.code);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
      errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
  endtask

  // One request, waits for accept then ack
  task automatic access(input logic is_rd, input logic [31:0] a, input logic [3:0] be,
                        input logic [31:0] d, output logic [31:0] rdata,
                        output int latency);
    int t;
    int acc_cycle;
    rdata   = '0;
    latency = -1;
    @(posedge clk_i);
    #1;
    rd_i    = is_rd;
    wr_i    = is_rd ? 4'h0 : be;
    addr_i  = a;
    wdata_i = d;
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!accept_o && t < 400);
    if (!accept_o) begin
      errors++;
      $display("Timeout waiting for accept at address %08h", a);
    end
    acc_cycle = cycle;
    @(posedge clk_i);
    #1;
    rd_i = 1'b0;
    wr_i = 4'h0;
    t = 0;
    while (!ack_o && t < 20) begin
      @(negedge clk_i);
      t++;
    end
    if (!ack_o) begin
      errors++;
      $display("Timeout waiting for ack at address %08h", a);
    end else begin
      latency = cycle - acc_cycle;
      rdata   = rdata_o;
    end
  endtask

  task automatic write_word(string name, logic [31:0] a, logic [3:0] be, logic [31:0] d);
    logic [31:0] unused;
    int          lat;
    access(1'b0, a, be, d, unused, lat);
    shadow[word_key(a)] = merge_word(shadow_read(word_key(a)), d, be);
    check_count({name, "_write_latency"}, 1, lat);
  endtask

  task automatic read_word(string name, logic [31:0] a);
    logic [31:0] got;
    int          lat;
    access(1'b1, a, 4'h0, 32'h0, got, lat);
    check_count({name, "_read_latency"}, 4, lat);
    check_word({name, "_data"}, shadow_read(word_key(a)), got);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int          t;
    int          base;
    int          refreshes;
    int          idx;
    int          clk_errors;
    int          early_cmds;
    logic [31:0] a;
    sdram_cmd_t  exp;
    rst_i   = 1'b1;
    wr_i    = '0;
    rd_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    repeat (5) @(posedge clk_i);
    #1 rst_i = 1'b0;

    // Init order
    begin_test();
    t = 0;
    clk_errors = 0;
    early_cmds = 0;
    while (i_model.log_cmd.size() < 4 && t < 6000) begin
      // Device clock runs opposite to the controller clock
      @(posedge clk_i);
      #1;
      if (sdram_clk !== 1'b0) begin
        clk_errors++;
      end
      @(negedge clk_i);
      #1;
      if (sdram_clk !== 1'b1) begin
        clk_errors++;
      end
      // Pins stay NOP while CKE is low
      if (!sdram_cke && {sdram_cs, sdram_ras, sdram_cas, sdram_we} !== CMD_NOP) begin
        early_cmds++;
      end
      t++;
    end
    check_count("init_sdram_clk_inverted", 0, clk_errors);
    check_count("init_nop_before_cke", 0, early_cmds);
    if (i_model.log_cmd.size() < 4) begin
      errors++;
      $display("Timeout waiting for the init command sequence");
    end else begin
      check_count("init_after_cke", 1, int'(i_model.log_cycle[0] > i_model.cke_cycle));
      exp.code = CMD_PRECHARGE;
      check_cmd("init_precharge", exp, i_model.log_cmd[0]);
      check_count("init_precharge_all", 1, int'(i_model.log_addr[0][ALL_BANKS_BIT]));
      exp.code = CMD_REFRESH;
      check_cmd("init_refresh_a", exp, i_model.log_cmd[1]);
      check_cmd("init_refresh_b", exp, i_model.log_cmd[2]);
      exp.code = CMD_LOAD_MODE;
      check_cmd("init_mode", exp, i_model.log_cmd[3]);
      check_word("init_mode_word", 32'(MODE_REG), 32'(i_model.log_addr[3]));
    end
    end_test("init_order");

    // Write then read
    begin_test();
    a = {6'd0, 13'd5, 2'd0, 9'd7, 2'd0};
    write_word("full_write", a, 4'hF, 32'hDEADBEEF);
    read_word("full_read", a);
    end_test("write_read");

    // Partial byte masks
    begin_test();
    write_word("mask_write", a, 4'b0101, 32'h11223344);
    read_word("mask_read", a);
    end_test("byte_mask");

    // Row miss in bank 0
    begin_test();
    base = i_model.log_cmd.size();
    a = {6'd0, 13'd77, 2'd0, 9'd3, 2'd0};
    read_word("miss_read", a);
    idx = -1;
    for (int i = base; i < i_model.log_cmd.size(); i++) begin
      if (idx < 0 && i_model.log_cmd[i].code == CMD_PRECHARGE &&
          !i_model.log_addr[i][ALL_BANKS_BIT]) idx = i;
    end
    if (idx < 0 || idx + 1 >= i_model.log_cmd.size()) begin
      errors++;
      $display("Row miss produced no bank precharge followed by a command");
    end else begin
      check_word("miss_precharge_bank", 32'd0, 32'(i_model.log_ba[idx]));
      exp.code = CMD_ACTIVE;
      check_cmd("miss_activate", exp, i_model.log_cmd[idx + 1]);
      check_word("miss_activate_row", 32'd77, 32'(i_model.log_addr[idx + 1]));
    end
    end_test("row_miss");

    // Idle refresh
    begin_test();
    base = i_model.log_cmd.size();
    repeat (2000) @(posedge clk_i);
    refreshes = 0;
    for (int i = base; i < i_model.log_cmd.size(); i++) begin
      if (i_model.log_cmd[i].code == CMD_REFRESH) begin
        refreshes++;
        check_count("refresh_rows_closed", 0, int'(i_model.log_open[i]));
      end
    end
    check_count("refresh_at_least_5", 1, int'(refreshes >= 5));
    end_test("refresh");

    // Random traffic over a small address pool
    begin_test();
    for (int n = 0; n < 40; n++) begin
      logic [31:0] op, bank, row, col, be, d;
      take_bits(1, op);
      take_bits(2, bank);
      take_bits(2, row);
      take_bits(3, col);
      take_bits(4, be);
      take_bits(32, d);
      a = {6'd0, 13'(row), 2'(bank), 9'(col), 2'd0};
      if (op[0]) begin
        read_word("rand_read", a);
      end else begin
        write_word("rand_write", a, (be[3:0] == 4'h0) ? 4'hF : be[3:0], d);
      end
    end
    check_count("model_access_errors", 0, i_model.access_errors);
    end_test("random_traffic");

    $display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/sdram_pkg.sv
logic/sdram_refresh_timer.sv
logic/sdram_bank_tracker.sv
logic/sdram_sequencer.sv
logic/sdram_cmd_issuer.sv
logic/sdram_read_path.sv
logic/sdram_ctrl_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_sdram_ctrl -o tb_sdram_ctrl
if [ $? -ne 0 ]; then
  echo "Compile step failed"
  exit 1
fi

./obj_dir/tb_sdram_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0
